// ==== include/uart_link_cfg.svh ====
`ifndef UART_LINK_CFG_SVH
`define UART_LINK_CFG_SVH

// data bits per frame.
`define UART_WORD_WIDTH 8

// ticks per bit. keep it even and at least 4.
`define UART_OVERSAMPLING 16

// clk cycles per tick.
// one bit lasts 64 clocks with these values.
`define UART_BAUD_DIV 4

`endif

// ==== logic/uart_link_pkg.sv ====
`default_nettype none

`include "uart_link_cfg.svh"

package uart_link_pkg;

   // one transmit request, taken on tx_start.
   typedef struct packed {
      logic [`UART_WORD_WIDTH-1:0] data;
      logic                        parity_en; // append odd parity.
   } tx_req_t;

   // one received frame.
   typedef struct packed {
      logic [`UART_WORD_WIDTH-1:0] data;
      logic                        parity_err; // ones count came out even.
      logic                        frame_err;  // stop bit sampled low.
   } rx_word_t;

endpackage

`default_nettype wire

// ==== logic/uart_baud_tick.sv ====
`default_nettype none

`include "uart_link_cfg.svh"

module uart_baud_tick (
   input wire clk,
   input wire rst_n,
   output logic tick
);

   localparam int DIV = `UART_BAUD_DIV;
   localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

   logic [CW-1:0] cnt;

   // first tick comes DIV clocks after reset.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= CW'(DIV - 1);
         tick <= 1'b0;
      end else if (cnt == '0) begin
         cnt <= CW'(DIV - 1); // reload.
         tick <= 1'b1;
      end else begin
         cnt <= cnt - CW'(1);
         tick <= 1'b0;
      end
   end

   a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
      (DIV > 1) && tick |=> !tick)
      else $error("tick held high for two cycles");

endmodule

`default_nettype wire

// ==== logic/uart_tx_ser.sv ====
`default_nettype none

`include "uart_link_cfg.svh"

module uart_tx_ser (
   input wire clk,
   input wire rst_n,
   input wire tick,
   input wire tx_start,
   input wire uart_link_pkg::tx_req_t req,
   output logic txd,
   output logic tx_busy
);

   localparam int WW = `UART_WORD_WIDTH;
   localparam int OS = `UART_OVERSAMPLING;
   localparam int TW = $clog2(OS);
   localparam int BW = $clog2(WW + 1);

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   tx_state_t state, state_nxt;
   logic [WW:0] shreg, shreg_nxt; // parity bit above the data.
   logic [TW-1:0] tick_cnt, tick_cnt_nxt;
   logic [BW-1:0] bit_cnt, bit_cnt_nxt;
   logic par_en, par_en_nxt;
   logic bit_done;
   logic txd_nxt;

   assign bit_done = tick && (tick_cnt == '0);
   assign tx_busy = (state != TX_IDLE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= TX_IDLE;
         tick_cnt <= '0;
         bit_cnt <= '0;
         par_en <= 1'b0;
         txd <= 1'b1; // idle line.
      end else begin
         state <= state_nxt;
         tick_cnt <= tick_cnt_nxt;
         bit_cnt <= bit_cnt_nxt;
         par_en <= par_en_nxt;
         txd <= txd_nxt;
      end
   end

   always_ff @(posedge clk) begin
      shreg <= shreg_nxt;
   end

   always_comb begin
      state_nxt = state;
      shreg_nxt = shreg;
      tick_cnt_nxt = tick_cnt;
      bit_cnt_nxt = bit_cnt;
      par_en_nxt = par_en;

      if (tick && state != TX_IDLE) begin
         tick_cnt_nxt = tick_cnt - TW'(1);
      end

      case (state)
         TX_IDLE: begin
            if (tx_start) begin
               shreg_nxt = {~(^req.data), req.data}; // odd parity.
               par_en_nxt = req.parity_en;
               tick_cnt_nxt = TW'(OS - 1);
               state_nxt = TX_START;
            end
         end
         TX_START: begin
            if (bit_done) begin
               tick_cnt_nxt = TW'(OS - 1);
               bit_cnt_nxt = par_en ? BW'(WW) : BW'(WW - 1);
               state_nxt = TX_DATA;
            end
         end
         TX_DATA: begin
            if (bit_done) begin
               tick_cnt_nxt = TW'(OS - 1);
               shreg_nxt = shreg >> 1; // lsb first.
               if (bit_cnt == '0) begin
                  state_nxt = TX_STOP;
               end else begin
                  bit_cnt_nxt = bit_cnt - BW'(1);
               end
            end
         end
         TX_STOP: begin
            if (bit_done) begin
               state_nxt = TX_IDLE;
            end
         end
         default: state_nxt = TX_IDLE;
      endcase

      // line level follows the state being entered.
      case (state_nxt)
         TX_START: txd_nxt = 1'b0;
         TX_DATA: txd_nxt = shreg_nxt[0];
         default: txd_nxt = 1'b1;
      endcase
   end

   a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
      tx_busy |-> !tx_start)
      else $error("tx_start while transmitter busy");

   a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
      (state == TX_IDLE) |-> txd)
      else $error("txd low while transmitter idle");

endmodule

`default_nettype wire

// ==== logic/uart_rx_des.sv ====
`default_nettype none

`include "uart_link_cfg.svh"

module uart_rx_des (
   input wire clk,
   input wire rst_n,
   input wire tick,
   input wire rxd,
   input wire parity_en,
   output logic rx_valid,
   output uart_link_pkg::rx_word_t rx_word
);

   import uart_link_pkg::*;

   localparam int WW = `UART_WORD_WIDTH;
   localparam int OS = `UART_OVERSAMPLING;
   localparam int TW = $clog2(OS);
   localparam int BW = $clog2(WW + 1);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t state, state_nxt;
   logic rxd_meta, rxd_sync, rxd_prev;
   logic [WW:0] shreg, shreg_nxt;
   logic [TW-1:0] tick_cnt, tick_cnt_nxt;
   logic [BW-1:0] bit_cnt, bit_cnt_nxt;
   logic par_en, par_en_nxt;
   logic fall;
   logic sample_pt;
   logic [WW-1:0] data_rcv;
   rx_word_t result;

   assign fall = rxd_prev & ~rxd_sync;
   assign sample_pt = tick && (tick_cnt == '0);

   // without parity the word ends one place higher.
   assign data_rcv = par_en ? shreg[WW-1:0] : shreg[WW:1];

   always_comb begin
      result.data = data_rcv;
      result.parity_err = par_en & ~(^shreg);
      result.frame_err = ~rxd_sync;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
         state <= RX_IDLE;
         tick_cnt <= '0;
         bit_cnt <= '0;
         par_en <= 1'b0;
         rx_valid <= 1'b0;
         rx_word <= '0;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
         state <= state_nxt;
         tick_cnt <= tick_cnt_nxt;
         bit_cnt <= bit_cnt_nxt;
         par_en <= par_en_nxt;
         rx_valid <= (state == RX_STOP) && sample_pt;
         if ((state == RX_STOP) && sample_pt) begin
            rx_word <= result; // held until the next frame.
         end
      end
   end

   always_ff @(posedge clk) begin
      shreg <= shreg_nxt;
   end

   always_comb begin
      state_nxt = state;
      shreg_nxt = shreg;
      tick_cnt_nxt = tick_cnt;
      bit_cnt_nxt = bit_cnt;
      par_en_nxt = par_en;

      if (tick && state != RX_IDLE) begin
         tick_cnt_nxt = tick_cnt - TW'(1);
      end

      case (state)
         RX_IDLE: begin
            if (fall) begin
               tick_cnt_nxt = TW'(OS / 2 - 1); // aim at mid start bit.
               par_en_nxt = parity_en;
               state_nxt = RX_START;
            end
         end
         RX_START: begin
            if (sample_pt) begin
               if (rxd_sync) begin
                  state_nxt = RX_IDLE; // line back high means a glitch.
               end else begin
                  tick_cnt_nxt = TW'(OS - 1);
                  bit_cnt_nxt = par_en ? BW'(WW) : BW'(WW - 1);
                  state_nxt = RX_DATA;
               end
            end
         end
         RX_DATA: begin
            if (sample_pt) begin
               tick_cnt_nxt = TW'(OS - 1);
               shreg_nxt = {rxd_sync, shreg[WW:1]}; // lsb arrives first.
               if (bit_cnt == '0) begin
                  state_nxt = RX_STOP;
               end else begin
                  bit_cnt_nxt = bit_cnt - BW'(1);
               end
            end
         end
         RX_STOP: begin
            // stop bit is checked in the register block.
            if (sample_pt) begin
               state_nxt = RX_IDLE;
            end
         end
         default: state_nxt = RX_IDLE;
      endcase
   end

   a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      rx_valid |=> !rx_valid)
      else $error("rx_valid longer than one cycle");

endmodule

`default_nettype wire

// ==== logic/uart_link_top.sv ====
`default_nettype none

`include "uart_link_cfg.svh"

module uart_link_top (
   input wire clk,
   input wire rst_n,
   input wire tx_start,
   input wire [`UART_WORD_WIDTH-1:0] tx_data,
   input wire parity_en,
   output logic tx_busy,
   output logic txd,
   input wire rxd,
   output logic rx_valid,
   output uart_link_pkg::rx_word_t rx_word
);

   import uart_link_pkg::*;

   logic tick;
   tx_req_t tx_req;

   // serializer takes the request on the tx_start edge.
   assign tx_req = '{data: tx_data, parity_en: parity_en};

   // one tick source shared by both directions.
   uart_baud_tick uart_baud_tick_inst (
      .clk (clk),
      .rst_n (rst_n),
      .tick (tick)
   );

   uart_tx_ser uart_tx_ser_inst (
      .clk (clk),
      .rst_n (rst_n),
      .tick (tick),
      .tx_start (tx_start),
      .req (tx_req),
      .txd (txd),
      .tx_busy (tx_busy)
   );

   uart_rx_des uart_rx_des_inst (
      .clk (clk),
      .rst_n (rst_n),
      .tick (tick),
      .rxd (rxd),
      .parity_en (parity_en), // same level as the transmit side.
      .rx_valid (rx_valid),
      .rx_word (rx_word)
   );

endmodule

`default_nettype wire

// ==== bench/uart_link_clkgen.sv ====
`default_nettype none

module uart_link_clkgen (
   output logic clk
);

   localparam int HALF = 5; // period of 10.

   initial begin
      clk = 1'b0;
   end

   always begin
      #HALF clk = ~clk;
   end

endmodule

`default_nettype wire

// ==== bench/uart_link_tb.sv ====
`default_nettype none

`include "uart_link_cfg.svh"

module uart_link_tb;

   import uart_link_pkg::*;

   localparam int WW = `UART_WORD_WIDTH;
   localparam int OS = `UART_OVERSAMPLING;
   localparam int DIV = `UART_BAUD_DIV;
   localparam int BIT_CLKS = OS * DIV;
   localparam int KW = (WW > 1) ? $clog2(WW) : 1;

   typedef enum logic [1:0] {
      F_NONE,
      F_FLIP,
      F_LOW_STOP,
      F_GLITCH
   } fault_t;

   typedef struct packed {
      logic [WW-1:0] data;
      logic          parity_en;
      fault_t        fault;
      logic [KW-1:0] k;      // data bit hit by F_FLIP.
      rx_word_t      exp;
   } row_t;

   logic clk;
   logic rst_n;
   logic tx_start;
   logic [WW-1:0] tx_data;
   logic parity_en;
   logic tx_busy;
   logic txd;
   logic rxd;
   logic rx_valid;
   rx_word_t rx_word;
   logic line_inv;
   logic line_low;
   logic busy_q = 1'b0;
   int busy_len = 0;
   int cycles = 0;
   int limit;
   int len_off;
   row_t rows[$];
   string names[$];

   // loopback wire that can invert the line or pull it low.
   assign rxd = line_low ? 1'b0 : (txd ^ line_inv);

   uart_link_clkgen uart_link_clkgen_inst (
      .clk (clk)
   );

   uart_link_top uart_link_top_inst (
      .clk (clk),
      .rst_n (rst_n),
      .tx_start (tx_start),
      .tx_data (tx_data),
      .parity_en (parity_en),
      .tx_busy (tx_busy),
      .txd (txd),
      .rxd (rxd),
      .rx_valid (rx_valid),
      .rx_word (rx_word)
   );

   task automatic stop_run();
      $display("TEST FAIL");
      $fatal(1, "simulation stopped at cycle %0d", cycles);
   endtask

   task automatic abort_with(string why);
      $display("%s", why);
      stop_run();
   endtask

   task automatic report_mismatch(string name, logic [WW+1:0] exp, logic [WW+1:0] act);
      $display("** Error %s expected %h actual %h", name, exp, act);
      stop_run();
   endtask

   function automatic int count_ones(logic [WW-1:0] w);
      int c;
      int b;
      c = 0;
      for (b = 0; b < WW; b++) begin
         if (w[b]) c++;
      end
      return c;
   endfunction

   // what the receiver should report for one frame.
   function automatic rx_word_t expect_word(logic [WW-1:0] data, logic par, fault_t f,
                                            logic [KW-1:0] k);
      rx_word_t w;
      logic [WW-1:0] seen_data;
      logic pbit;
      seen_data = data;
      if (f == F_FLIP) seen_data[k] = ~data[k];
      pbit = (count_ones(data) % 2) == 0; // makes the sent ones count odd.
      w.data = seen_data;
      w.parity_err = par && (((count_ones(seen_data) + int'(pbit)) % 2) == 0);
      w.frame_err = (f == F_LOW_STOP);
      return w;
   endfunction

   task automatic add_row(string name, logic [WW-1:0] data, logic par, fault_t f,
                          logic [KW-1:0] k);
      row_t r;
      r.data = data;
      r.parity_en = par;
      r.fault = f;
      r.k = k;
      if (f == F_GLITCH && rows.size() > 0) begin
         r.exp = rows[rows.size() - 1].exp; // the last result stays in place.
      end else begin
         r.exp = expect_word(data, par, f, k);
      end
      rows.push_back(r);
      names.push_back(name);
   endtask

   task automatic build_table();
      logic [WW-1:0] words [12];
      int i;
      words[0] = '0;
      words[1] = '1;
      words[2] = WW'(8'ha5);
      words[3] = WW'(8'h5a);
      for (i = 4; i < 12; i++) begin
         words[i] = WW'($urandom());
      end
      for (i = 0; i < 12; i++) begin
         add_row($sformatf("plain_%0d", i), words[i], 1'b0, F_NONE, '0);
      end
      for (i = 0; i < 12; i++) begin
         add_row($sformatf("parity_%0d", i), words[i], 1'b1, F_NONE, '0);
      end
      add_row("flip_lsb", WW'(8'ha5), 1'b1, F_FLIP, '0);
      add_row("flip_msb", WW'(8'h5a), 1'b1, F_FLIP, KW'(WW - 1));
      add_row("flip_rand", WW'($urandom()), 1'b1, F_FLIP, KW'($urandom() % WW));
      add_row("stop_low_nopar", WW'(8'h3c), 1'b0, F_LOW_STOP, '0);
      add_row("stop_low_par", WW'(8'hc3), 1'b1, F_LOW_STOP, '0);
      add_row("glitch", '0, 1'b0, F_GLITCH, '0);
      add_row("after_glitch", WW'(8'h96), 1'b1, F_NONE, '0);
   endtask

   // one frame through the loopback with the row's fault applied.
   task automatic run_frame(int i);
      row_t r;
      rx_word_t got;
      int n;
      int lo;
      int hi;
      int stop_idx;
      bit seen;
      r = rows[i];
      stop_idx = 1 + WW + (r.parity_en ? 1 : 0);
      lo = 0;
      hi = 0;
      if (r.fault == F_FLIP) begin
         lo = BIT_CLKS * (int'(r.k) + 1) + BIT_CLKS / 8;
         hi = BIT_CLKS * (int'(r.k) + 2) - BIT_CLKS / 8;
      end else if (r.fault == F_LOW_STOP) begin
         lo = BIT_CLKS * stop_idx + BIT_CLKS / 8;
         hi = BIT_CLKS * (stop_idx + 1) - BIT_CLKS / 8;
      end
      @(posedge clk);
      tx_data <= r.data;
      parity_en <= r.parity_en;
      tx_start <= 1'b1;
      @(posedge clk);
      tx_start <= 1'b0;
      while (txd !== 1'b0) @(posedge clk);
      n = 0; // counts clocks from the start-bit fall.
      seen = 1'b0;
      while (!seen || tx_busy) begin
         @(posedge clk);
         n++;
         line_inv <= (r.fault == F_FLIP) && (n >= lo) && (n < hi);
         line_low <= (r.fault == F_LOW_STOP) && (n >= lo) && (n < hi);
         if (rx_valid) begin
            assert (!seen)
               else abort_with($sformatf("%s: two results for one frame", names[i]));
            seen = 1'b1;
            got = rx_word;
         end
      end
      line_inv <= 1'b0;
      line_low <= 1'b0;
      assert (got == r.exp) else report_mismatch(names[i], r.exp, got);
      if (r.fault == F_NONE && !r.parity_en) len_off = busy_len;
      if (r.fault == F_NONE && r.parity_en) begin
         assert (len_off > 0 && busy_len - len_off >= BIT_CLKS - DIV &&
                 busy_len - len_off <= BIT_CLKS + DIV)
            else abort_with($sformatf("%s: frame with parity lasts %0d clocks, without %0d",
                                      names[i], busy_len, len_off));
      end
   endtask

   // short low pulse on an idle line must not make a frame.
   task automatic run_glitch(int i);
      int n;
      @(posedge clk);
      line_low <= 1'b1;
      repeat (BIT_CLKS / 8) @(posedge clk);
      line_low <= 1'b0;
      for (n = 0; n < 12 * BIT_CLKS; n++) begin
         @(posedge clk);
         assert (!rx_valid)
            else abort_with($sformatf("%s: rx_valid after a line glitch", names[i]));
      end
      assert (rx_word == rows[i].exp) else report_mismatch(names[i], rows[i].exp, rx_word);
   endtask

   always @(posedge clk) begin
      busy_q <= tx_busy;
      if (tx_busy && !busy_q) busy_len <= 1;
      else if (tx_busy) busy_len <= busy_len + 1;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         abort_with("timeout: no result from the receiver");
      end
   end

   initial begin
      rst_n = 1'b0;
      tx_start = 1'b0;
      tx_data = '0;
      parity_en = 1'b0;
      line_inv = 1'b0;
      line_low = 1'b0;
      limit = 0;
      len_off = 0;
      void'($urandom(32'h4c9b));
      build_table();
      limit = rows.size() * 12 * OS * DIV * 2;
      @(posedge clk);
      repeat (7) begin
         @(posedge clk);
         assert (rx_valid === 1'b0) else abort_with("rx_valid high during reset");
      end
      rst_n <= 1'b1;
      repeat (20) begin
         @(posedge clk);
         assert (txd === 1'b1 && tx_busy === 1'b0 && rx_valid === 1'b0)
            else abort_with("line or handshake not idle after reset");
         assert (rx_word === '0) else report_mismatch("reset", '0, rx_word);
      end
      foreach (rows[i]) begin
         if (rows[i].fault == F_GLITCH) run_glitch(i);
         else run_frame(i);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== uart_link.f ====
+incdir+include
logic/uart_link_pkg.sv
logic/uart_baud_tick.sv
logic/uart_tx_ser.sv
logic/uart_rx_des.sv
logic/uart_link_top.sv
bench/uart_link_clkgen.sv
bench/uart_link_tb.sv

// ==== Makefile ====
# Verilator flow for the UART link core.
# Any variable below can be overridden on the command line, e.g. make sim SEED=7

VERILATOR ?= verilator
TOP       ?= uart_link_tb
RTL_TOP   ?= uart_link_top
SEED      ?= 1
LOG       ?= sim.log
FILELIST  ?= uart_link.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -Iinclude logic/uart_link_pkg.sv logic/uart_baud_tick.sv \
		logic/uart_tx_ser.sv logic/uart_rx_des.sv logic/uart_link_top.sv \
		--top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the run log decides the verdict, the exit status of the binary is not used.
sim: build
	rm -f $(LOG)
	-$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
